// File: src.f
+incdir+src
src/ml_ops_pkg.sv
src/ml_desc_regs.sv
src/ml_addr_gen.sv
src/ml_seq_fsm.sv
src/ml_datapath.sv
src/ml_batch_fifo.sv
src/ml_ops_top.sv
tests/ml_ops_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= ml_ops_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/ml_ops_tb.sv
module ml_ops_tb;
  import ml_ops_pkg::*;

  localparam int NUM_OPS     = 8;
  localparam int CYCLE_LIMIT = 200 * NUM_OPS + 100;

  logic  clk_i;
  logic  rst_i;
  logic  ml_ops_enable_i;
  logic  loading_data_i;
  logic  relu_en_i;
  logic  dotp_en_i;
  logic  ex_ready_i;
  addr_t operand_a_addr_i;
  len_t  operand_b_size_i;
  word_t mem_rd_data_i = '0;
  word_t reg_wr_data_o;
  word_t mem_wr_data_o;
  addr_t mem_addr_o;
  logic  mem_rd_en_o;
  logic  mem_wr_en_o;
  logic  reg_wr_en_o;
  logic  ml_op_done_o;
  logic  ml_ready_o;

  logic [31:0] lfsr_q;
  int          cycle_cnt = 0;
  // source words preloaded by the test and the words the DUT writes
  word_t       rmem [addr_t];
  word_t       wmem [addr_t];
  int          wr_cnt [addr_t];
  int          wr_total = 0;
  int          reg_wr_cnt = 0;
  word_t       reg_wr_val = '0;
  logic        rd_pend_q;
  addr_t       rd_pend_addr_q;
  addr_t       dst_lo;
  addr_t       dst_hi;

  ml_ops_top dut_i (.*);

  always #2 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic word_t read_mem(input addr_t a);
    if (rmem.exists(a)) begin
      return rmem[a];
    end
    return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  // memory model with one cycle of read latency
  always @(negedge clk_i) begin
    if (!rst_i) begin
      mem_rd_data_i = '0;
      rd_pend_q     = 1'b0;
    end else begin
      if (rd_pend_q) begin
        mem_rd_data_i = read_mem(rd_pend_addr_q);
      end
      rd_pend_q      = mem_rd_en_o;
      rd_pend_addr_q = mem_addr_o;
      if (mem_wr_en_o) begin
        if (mem_addr_o < dst_lo || mem_addr_o >= dst_hi) begin
          $display("memory write to %h lies outside the destination range", mem_addr_o);
          abort_run();
        end
        if (!wr_cnt.exists(mem_addr_o)) begin
          wr_cnt[mem_addr_o] = 0;
        end
        wr_cnt[mem_addr_o] = wr_cnt[mem_addr_o] + 1;
        wmem[mem_addr_o]   = mem_wr_data_o;
        wr_total           = wr_total + 1;
      end
      if (reg_wr_en_o) begin
        reg_wr_cnt = reg_wr_cnt + 1;
        reg_wr_val = reg_wr_data_o;
      end
      if (!mem_rd_en_o && !mem_wr_en_o) begin
        check_addr("mem_addr_o", mem_addr_o, '0);
      end
    end
  end

  task automatic run_op(input logic is_relu, input len_t n, input int op_idx);
    addr_t src;
    addr_t dst;
    addr_t a;
    word_t x;
    word_t y;
    word_t sum;
    word_t exp_w;
    int    wr_before;
    int    reg_before;
    int    hold;
    // each operation gets its own address window
    src = 32'h1000_0000 + (addr_t'(op_idx) << 16) + (rand_bits(10) << 2);
    dst = 32'h2000_0000 + (addr_t'(op_idx) << 16) + (rand_bits(10) << 2);
    sum = '0;
    for (int i = 0; i < int'(n); i++) begin
      x = rand_bits(32);
      rmem[src + addr_t'(4 * i)] = x;
      if (!is_relu) begin
        y = rand_bits(32);
        rmem[dst + addr_t'(4 * i)] = y;
        sum = sum + x * y;
      end
    end
    dst_lo     = is_relu ? dst : '0;
    dst_hi     = is_relu ? dst + addr_t'(4 * int'(n)) : '0;
    wr_before  = wr_total;
    reg_before = reg_wr_cnt;

    ml_ops_enable_i  = 1'b1;
    relu_en_i        = is_relu;
    dotp_en_i        = !is_relu;
    ex_ready_i       = 1'b0;
    loading_data_i   = 1'b1;
    operand_a_addr_i = src;
    operand_b_size_i = n;
    @(negedge clk_i);
    operand_a_addr_i = dst;
    operand_b_size_i = rand_bits(32);
    @(negedge clk_i);
    loading_data_i   = 1'b0;
    operand_a_addr_i = '0;
    operand_b_size_i = '0;
    @(negedge clk_i);
    while (!ml_op_done_o) begin
      check_bit("ml_ready_o", ml_ready_o, 1'b0);
      @(negedge clk_i);
    end

    // done must hold until ex_ready_i
    hold = int'(rand_bits(4)) + 1;
    repeat (hold) begin
      check_bit("ml_op_done_o", ml_op_done_o, 1'b1);
      check_bit("ml_ready_o", ml_ready_o, 1'b1);
      @(negedge clk_i);
    end
    check_bit("ml_op_done_o", ml_op_done_o, 1'b1);
    ex_ready_i = 1'b1;
    @(negedge clk_i);
    check_bit("ml_op_done_o", ml_op_done_o, 1'b0);
    ex_ready_i      = 1'b0;
    ml_ops_enable_i = 1'b0;
    relu_en_i       = 1'b0;
    dotp_en_i       = 1'b0;

    if (is_relu) begin
      for (int i = 0; i < int'(n); i++) begin
        a = dst + addr_t'(4 * i);
        x = rmem[src + addr_t'(4 * i)];
        if (!wmem.exists(a)) begin
          $display("destination word %h was never written", a);
          abort_run();
        end
        // negative words become zero
        exp_w = ($signed(x) < 0) ? word_t'(0) : x;
        check_word($sformatf("mem_wr_data_o @%h", a), wmem[a], exp_w);
        check_word($sformatf("write count @%h", a), word_t'(wr_cnt[a]), 32'd1);
      end
      check_word("mem_wr_en_o count", word_t'(wr_total - wr_before), n);
      check_word("reg_wr_en_o count", word_t'(reg_wr_cnt - reg_before), '0);
    end else begin
      check_word("reg_wr_en_o count", word_t'(reg_wr_cnt - reg_before), 32'd1);
      check_word("reg_wr_data_o", reg_wr_val, sum);
    end
  endtask

  initial begin
    lfsr_q           = 32'h12028804;
    clk_i            = 1'b0;
    rst_i            = 1'b0;
    ml_ops_enable_i  = 1'b0;
    loading_data_i   = 1'b0;
    relu_en_i        = 1'b0;
    dotp_en_i        = 1'b0;
    ex_ready_i       = 1'b0;
    operand_a_addr_i = '0;
    operand_b_size_i = '0;
    dst_lo           = '0;
    dst_hi           = '0;
    repeat (8) @(negedge clk_i);
    rst_i = 1'b1;
    @(negedge clk_i);
    check_bit("mem_rd_en_o", mem_rd_en_o, 1'b0);
    check_bit("mem_wr_en_o", mem_wr_en_o, 1'b0);
    check_bit("reg_wr_en_o", reg_wr_en_o, 1'b0);
    check_bit("ml_op_done_o", ml_op_done_o, 1'b0);
    check_bit("ml_ready_o", ml_ready_o, 1'b1);

    run_op(1'b1, len_t'(rand_bits(4) % 15 + 1), 0);
    run_op(1'b1, len_t'(16), 1);
    run_op(1'b1, len_t'(17), 2);
    run_op(1'b1, len_t'(37), 3);
    run_op(1'b0, len_t'(rand_bits(6) % 40 + 1), 4);
    // mixed operations back to back
    for (int k = 5; k < NUM_OPS; k++) begin
      run_op(rand_bits(1) != 0, len_t'(rand_bits(6) % 40 + 1), k);
    end

    $display("Everything OK");
    $finish;
  end

endmodule

// File: src/ml_ops_top.sv
module ml_ops_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ml_ops_enable_i,
  input  logic              loading_data_i,
  input  logic              relu_en_i,
  input  logic              dotp_en_i,
  input  logic              ex_ready_i,
  input  ml_ops_pkg::addr_t operand_a_addr_i,
  input  ml_ops_pkg::len_t  operand_b_size_i,
  input  ml_ops_pkg::word_t mem_rd_data_i,
  output ml_ops_pkg::word_t reg_wr_data_o,
  output ml_ops_pkg::word_t mem_wr_data_o,
  output ml_ops_pkg::addr_t mem_addr_o,
  output logic              mem_rd_en_o,
  output logic              mem_wr_en_o,
  output logic              reg_wr_en_o,
  output logic              ml_op_done_o,
  output logic              ml_ready_o
);
  import ml_ops_pkg::*;

  addr_t      src_addr;
  addr_t      dst_addr;
  len_t       src_len;
  logic       rd_sel;
  logic       rd_last;
  logic       ptr_load;
  logic       acc_clr;
  logic       push;
  logic       result_valid;
  logic       fifo_empty;
  word_t      relu_data;
  batch_cnt_t fill;

  ml_desc_regs desc_regs_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .enable_i   (ml_ops_enable_i),
    .load_i     (loading_data_i),
    .clear_i    (ml_op_done_o),
    .addr_i     (operand_a_addr_i),
    .size_i     (operand_b_size_i),
    .src_addr_o (src_addr),
    .dst_addr_o (dst_addr),
    .src_len_o  (src_len)
  );

  ml_seq_fsm seq_fsm_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .enable_i       (ml_ops_enable_i),
    .loading_i      (loading_data_i),
    .relu_en_i      (relu_en_i),
    .dotp_en_i      (dotp_en_i),
    .ex_ready_i     (ex_ready_i),
    .fifo_empty_i   (fifo_empty),
    .result_valid_i (result_valid),
    .fill_i         (fill),
    .src_len_i      (src_len),
    .rd_en_o        (mem_rd_en_o),
    .rd_sel_o       (rd_sel),
    .rd_last_o      (rd_last),
    .wr_en_o        (mem_wr_en_o),
    .ptr_load_o     (ptr_load),
    .acc_clr_o      (acc_clr),
    .reg_wr_en_o    (reg_wr_en_o),
    .done_o         (ml_op_done_o),
    .ready_o        (ml_ready_o)
  );

  ml_addr_gen addr_gen_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ptr_load_i (ptr_load),
    .rd_en_i    (mem_rd_en_o),
    .rd_sel_i   (rd_sel),
    .wr_en_i    (mem_wr_en_o),
    .src_addr_i (src_addr),
    .dst_addr_i (dst_addr),
    .mem_addr_o (mem_addr_o)
  );

  ml_datapath datapath_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rd_en_i        (mem_rd_en_o),
    .rd_sel_i       (rd_sel),
    .rd_last_i      (rd_last),
    .acc_clr_i      (acc_clr),
    .relu_en_i      (relu_en_i),
    .rd_data_i      (mem_rd_data_i),
    .push_o         (push),
    .result_valid_o (result_valid),
    .relu_data_o    (relu_data),
    .acc_o          (reg_wr_data_o)
  );

  ml_batch_fifo batch_fifo_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push),
    .pop_i   (mem_wr_en_o),
    .din_i   (relu_data),
    .dout_o  (mem_wr_data_o),
    .fill_o  (fill),
    .empty_o (fifo_empty)
  );

endmodule

// File: src/ml_batch_fifo.sv
`include "ml_ops_config.svh"

module ml_batch_fifo (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   push_i,
  input  logic                   pop_i,
  input  ml_ops_pkg::word_t      din_i,
  output ml_ops_pkg::word_t      dout_o,
  output ml_ops_pkg::batch_cnt_t fill_o,
  output logic                   empty_o
);
  import ml_ops_pkg::*;

  localparam int PTR_W = $clog2(`ML_BATCH);

  word_t            mem_q [`ML_BATCH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  batch_cnt_t       fill_q;
  logic             do_pop;

  assign do_pop = pop_i && (fill_q != '0);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= din_i;
    end
  end

  // pointers wrap at the depth
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   fill_q <= fill_q + batch_cnt_t'(1);
        2'b01:   fill_q <= fill_q - batch_cnt_t'(1);
        default: fill_q <= fill_q;
      endcase
    end
  end

  // head word visible for a same cycle write
  assign dout_o  = mem_q[rd_ptr_q];
  assign fill_o  = fill_q;
  assign empty_o = (fill_q == '0);

endmodule

// File: src/ml_datapath.sv
`include "ml_ops_config.svh"

module ml_datapath (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              rd_en_i,
  input  logic              rd_sel_i,
  input  logic              rd_last_i,
  input  logic              acc_clr_i,
  input  logic              relu_en_i,
  input  ml_ops_pkg::word_t rd_data_i,
  output logic              push_o,
  output logic              result_valid_o,
  output ml_ops_pkg::word_t relu_data_o,
  output ml_ops_pkg::word_t acc_o
);
  import ml_ops_pkg::*;

  logic  rd_v_q;
  logic  rd_sel_q;
  logic  rd_last_q;
  logic  mac_v_q;
  logic  mac_last_q;
  word_t a_q;
  word_t b_q;

  // read strobes lined up with the data coming back
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      rd_v_q     <= 1'b0;
      rd_sel_q   <= 1'b0;
      rd_last_q  <= 1'b0;
      mac_v_q    <= 1'b0;
      mac_last_q <= 1'b0;
      push_o     <= 1'b0;
    end else begin
      rd_v_q     <= rd_en_i;
      rd_sel_q   <= rd_sel_i;
      rd_last_q  <= rd_last_i;
      mac_v_q    <= rd_v_q && rd_sel_q;
      mac_last_q <= rd_v_q && rd_sel_q && rd_last_q;
      push_o     <= rd_v_q && relu_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_q && !rd_sel_q) begin
      a_q <= rd_data_i;
    end
    if (rd_v_q && rd_sel_q) begin
      b_q <= rd_data_i;
    end
    // sign bit set means negative for ints and floats alike
    relu_data_o <= rd_data_i[`ML_DATA_W-1] ? '0 : rd_data_i;
  end

  // a_q still holds the matching a word while b_q is consumed
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      acc_o          <= '0;
      result_valid_o <= 1'b0;
    end else if (acc_clr_i) begin
      acc_o          <= '0;
      result_valid_o <= 1'b0;
    end else if (mac_v_q) begin
      acc_o <= acc_o + a_q * b_q;
      if (mac_last_q) begin
        result_valid_o <= 1'b1;
      end
    end
  end

endmodule

// File: src/ml_seq_fsm.sv
`include "ml_ops_config.svh"

module ml_seq_fsm (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   enable_i,
  input  logic                   loading_i,
  input  logic                   relu_en_i,
  input  logic                   dotp_en_i,
  input  logic                   ex_ready_i,
  input  logic                   fifo_empty_i,
  input  logic                   result_valid_i,
  input  ml_ops_pkg::batch_cnt_t fill_i,
  input  ml_ops_pkg::len_t       src_len_i,
  output logic                   rd_en_o,
  output logic                   rd_sel_o,
  output logic                   rd_last_o,
  output logic                   wr_en_o,
  output logic                   ptr_load_o,
  output logic                   acc_clr_o,
  output logic                   reg_wr_en_o,
  output logic                   done_o,
  output logic                   ready_o
);
  import ml_ops_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;
  len_t       remain_q;
  len_t       left;
  batch_cnt_t rd_cnt_q;
  batch_cnt_t batch_len_q;
  logic       last_batch_q;
  logic       sel_q;
  logic       batch_end;
  logic       batch_start;
  logic       dotp_end;

  // elements still to read, taken straight from the descriptor at start
  assign left        = (state_q == SET_ADDR) ? src_len_i : remain_q;
  assign batch_end   = (rd_cnt_q + batch_cnt_t'(1)) == batch_len_q;
  assign batch_start = (state_d == RELU_TAKE) && (state_q != RELU_TAKE);
  assign dotp_end    = sel_q && (remain_q == len_t'(1));

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q      <= IDLE;
      remain_q     <= '0;
      rd_cnt_q     <= '0;
      batch_len_q  <= '0;
      last_batch_q <= 1'b0;
      sel_q        <= 1'b0;
    end else if (!enable_i) begin
      state_q <= IDLE;
      sel_q   <= 1'b0;
    end else begin
      state_q <= state_d;

      if (state_q == SET_ADDR) begin
        remain_q <= src_len_i;
      end else if (rd_en_o && (state_q == RELU_TAKE || sel_q)) begin
        remain_q <= remain_q - len_t'(1);
      end

      // a then b during a dot product
      if (state_q == SET_ADDR) begin
        sel_q <= 1'b0;
      end else if (state_q == DOTP_TAKE) begin
        sel_q <= ~sel_q;
      end

      if (batch_start) begin
        rd_cnt_q     <= '0;
        last_batch_q <= left <= len_t'(`ML_BATCH);
        if (left >= len_t'(`ML_BATCH)) begin
          batch_len_q <= batch_cnt_t'(`ML_BATCH);
        end else begin
          batch_len_q <= batch_cnt_t'(left);
        end
      end else if (state_q == RELU_TAKE) begin
        rd_cnt_q <= rd_cnt_q + batch_cnt_t'(1);
      end
    end
  end

  always_comb begin
    state_d     = state_q;
    rd_en_o     = 1'b0;
    rd_last_o   = 1'b0;
    wr_en_o     = 1'b0;
    ptr_load_o  = 1'b0;
    acc_clr_o   = 1'b0;
    reg_wr_en_o = 1'b0;
    done_o      = 1'b0;
    ready_o     = 1'b0;
    case (state_q)
      IDLE: begin
        ready_o = 1'b1;
        if (loading_i) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        ready_o = 1'b1;
        if (!loading_i) begin
          state_d = SET_ADDR;
        end
      end
      SET_ADDR: begin
        ptr_load_o = 1'b1;
        acc_clr_o  = 1'b1;
        if (relu_en_i) begin
          state_d = RELU_TAKE;
        end else if (dotp_en_i) begin
          state_d = DOTP_TAKE;
        end else begin
          state_d = DONE;
        end
      end
      RELU_TAKE: begin
        rd_en_o   = 1'b1;
        rd_last_o = batch_end && last_batch_q;
        if (batch_end) begin
          state_d = RELU_WAIT;
        end
      end
      RELU_WAIT: begin
        if (fill_i == batch_len_q) begin
          state_d = RELU_GIVE;
        end
      end
      RELU_GIVE: begin
        if (fifo_empty_i) begin
          state_d = last_batch_q ? DONE : RELU_TAKE;
        end else begin
          wr_en_o = 1'b1;
        end
      end
      DOTP_TAKE: begin
        rd_en_o   = 1'b1;
        rd_last_o = dotp_end;
        if (dotp_end) begin
          state_d = DOTP_WAIT;
        end
      end
      DOTP_WAIT: begin
        if (result_valid_i) begin
          state_d = DOTP_GIVE;
        end
      end
      DOTP_GIVE: begin
        reg_wr_en_o = 1'b1;
        state_d     = DONE;
      end
      DONE: begin
        done_o  = 1'b1;
        ready_o = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign rd_sel_o = (state_q == DOTP_TAKE) && sel_q;

endmodule

// File: src/ml_addr_gen.sv
`include "ml_ops_config.svh"

module ml_addr_gen (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ptr_load_i,
  input  logic              rd_en_i,
  input  logic              rd_sel_i,
  input  logic              wr_en_i,
  input  ml_ops_pkg::addr_t src_addr_i,
  input  ml_ops_pkg::addr_t dst_addr_i,
  output ml_ops_pkg::addr_t mem_addr_o
);
  import ml_ops_pkg::*;

  addr_t ptr_a_q;
  addr_t ptr_b_q;
  addr_t ptr_w_q;
  addr_t rd_addr;

  // vector b and the relu destination share the second slot
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      ptr_a_q <= '0;
      ptr_b_q <= '0;
      ptr_w_q <= '0;
    end else if (ptr_load_i) begin
      ptr_a_q <= src_addr_i;
      ptr_b_q <= dst_addr_i;
      ptr_w_q <= dst_addr_i;
    end else begin
      if (rd_en_i && !rd_sel_i) begin
        ptr_a_q <= ptr_a_q + addr_t'(`ML_WORD_BYTES);
      end
      if (rd_en_i && rd_sel_i) begin
        ptr_b_q <= ptr_b_q + addr_t'(`ML_WORD_BYTES);
      end
      if (wr_en_i) begin
        ptr_w_q <= ptr_w_q + addr_t'(`ML_WORD_BYTES);
      end
    end
  end

  assign rd_addr = rd_sel_i ? ptr_b_q : ptr_a_q;

  // idle bus shows zero
  always_comb begin
    if (wr_en_i) begin
      mem_addr_o = ptr_w_q;
    end else if (rd_en_i) begin
      mem_addr_o = rd_addr;
    end else begin
      mem_addr_o = '0;
    end
  end

endmodule

// File: src/ml_desc_regs.sv
`include "ml_ops_config.svh"

module ml_desc_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              enable_i,
  input  logic              load_i,
  input  logic              clear_i,
  input  ml_ops_pkg::addr_t addr_i,
  input  ml_ops_pkg::len_t  size_i,
  output ml_ops_pkg::addr_t src_addr_o,
  output ml_ops_pkg::addr_t dst_addr_o,
  output ml_ops_pkg::len_t  src_len_o
);
  import ml_ops_pkg::*;

  desc_idx_t slot_q;
  addr_t     addr_q [`ML_DESC_NUM];
  len_t      len_q;

  // one slot per load cycle, restart after each operation
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      slot_q <= '0;
    end else if (!enable_i || clear_i) begin
      slot_q <= '0;
    end else if (load_i) begin
      slot_q <= desc_idx_t'(slot_q + 1'b1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enable_i && load_i) begin
      addr_q[slot_q] <= addr_i;
      // destination size is not needed
      if (slot_q == '0) begin
        len_q <= size_i;
      end
    end
  end

  assign src_addr_o = addr_q[0];
  assign dst_addr_o = addr_q[1];
  assign src_len_o  = len_q;

endmodule

// File: src/ml_ops_pkg.sv
`include "ml_ops_config.svh"

package ml_ops_pkg;

  typedef logic [`ML_DATA_W-1:0] word_t;
  typedef logic [`ML_DATA_W-1:0] addr_t;
  typedef logic [`ML_DATA_W-1:0] len_t;

  // 0 to ML_BATCH inclusive
  typedef logic [$clog2(`ML_BATCH):0] batch_cnt_t;
  typedef logic [$clog2(`ML_DESC_NUM)-1:0] desc_idx_t;

  typedef enum logic [3:0] {
    IDLE,
    LOAD,
    SET_ADDR,
    RELU_TAKE,
    RELU_WAIT,
    RELU_GIVE,
    DOTP_TAKE,
    DOTP_WAIT,
    DOTP_GIVE,
    DONE
  } seq_state_t;

endpackage

// File: src/ml_ops_config.svh
`ifndef ML_OPS_CONFIG_SVH
`define ML_OPS_CONFIG_SVH

// data word and byte address width
`define ML_DATA_W 32

// words per relu batch, also the buffer depth
`define ML_BATCH 16

// source and destination slots
`define ML_DESC_NUM 2

// address step between consecutive words
`define ML_WORD_BYTES 4

`endif
